//--- Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dataCacheL1Tb
FILELIST  ?= dataCacheL1.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+1000

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) $(SIMFLAGS) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dataCacheL1.f
source/cachePkg.sv
source/cacheLineStore.sv
source/mainMemory.sv
source/cacheController.sv
source/dataCacheL1.sv
sim/dataCacheL1_asserts.sv
sim/clockGen.sv
sim/dataCacheL1Tb.sv

//--- sim/clockGen.sv
// Testbench clock and reset source with a 4 ns period and a fixed reset length
`timescale 1ns/10ps

module clockGen #(
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic rstN
);

    // Half period of 2 ns
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for the given cycles, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

//--- sim/dataCacheL1Tb.sv
// Testbench for the level-one data cache, checking values and hits against a reference model
`timescale 1ns/10ps

module dataCacheL1Tb;

    localparam int IndexBits = 4;
    localparam int OffsetBits = cachePkg::OffsetBits;
    localparam int TagBits = cachePkg::AddrWidth - IndexBits - OffsetBits;
    localparam int ResetCycles = 10;
    localparam int RandomOps = 200;
    // Cold reads, write then read, eviction, random mix
    localparam int Requests = 2 + 2 + 3 + RandomOps;
    localparam int WatchdogCycles = Requests * 30 + ResetCycles;
    localparam int DoneTimeout = 40;

    logic           clk;
    logic           rstN;
    logic           read;
    logic           write;
    cachePkg::addrT address;
    cachePkg::wordT writeValue;
    logic           busy;
    logic           done;
    logic           hit;
    cachePkg::wordT readValue;

    // Reference memory, starts cleared like the backing memory
    cachePkg::wordT     refMem [1 << cachePkg::AddrWidth] = '{default: '0};
    // Resident tag per index predicts hit
    logic [TagBits-1:0] residentTag [1 << IndexBits];
    logic               residentValid [1 << IndexBits];

    int          errors = 0;
    int          checks = 0;
    int          testsRun = 0;
    logic [31:0] rngState = 32'h31af;

    clockGen #(
        .ResetCycles(ResetCycles)
    ) clockSource (
        .clk(clk),
        .rstN(rstN)
    );

    dataCacheL1 #(
        .IndexBits(IndexBits)
    ) DUT (
        .clk(clk),
        .rstN(rstN),
        .read(read),
        .write(write),
        .address(address),
        .writeValue(writeValue),
        .busy(busy),
        .done(done),
        .hit(hit),
        .readValue(readValue)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Own checks plus bound assertion failures
    function automatic int totalErrors();
        return errors + DUT.asserts.failCount;
    endfunction

    // One request, driven on falling edges, checked on done
    task automatic request(input string name, input logic doRead, input logic doWrite,
                           input cachePkg::addrT addr, input cachePkg::wordT value);
        logic [IndexBits-1:0] idx;
        logic [TagBits-1:0]   tag;
        logic                 expHit;
        cachePkg::wordT       expValue;
        int                   waited;
        idx = addr[OffsetBits +: IndexBits];
        tag = addr[cachePkg::AddrWidth-1 -: TagBits];
        expHit = residentValid[idx] && (residentTag[idx] == tag);
        expValue = refMem[addr];
        waited = 0;
        while (busy) @(negedge clk);
        read = doRead;
        write = doWrite;
        address = addr;
        writeValue = value;
        @(negedge clk);
        read = 1'b0;
        write = 1'b0;
        while (!done && waited < DoneTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("%s: done did not arrive within %0d cycles", name, DoneTimeout);
            errors++;
            return;
        end
        checks++;
        assert (hit == expHit) else begin
            $display("[FAIL] %s hit: expected %0b, actual %0b", name, expHit, hit);
            errors++;
        end
        // Write wins when both strobes are set
        if (doWrite) begin
            refMem[addr] = value;
        end else begin
            checks++;
            assert (readValue == expValue) else begin
                $display("[FAIL] %s readValue at %h: expected %h, actual %h",
                         name, addr, expValue, readValue);
                errors++;
            end
        end
        // Write-allocate, so every access leaves its line resident
        residentValid[idx] = 1'b1;
        residentTag[idx] = tag;
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testsRun++;
        $display("test %s finished, %0d errors", name, totalErrors() - startErrors);
    endtask

    initial begin
        int             startErrors;
        cachePkg::addrT addr;
        logic [31:0]    r;
        read = 1'b0;
        write = 1'b0;
        address = '0;
        writeValue = '0;
        foreach (residentValid[i]) begin
            residentValid[i] = 1'b0;
            residentTag[i] = '0;
        end

        // Reset outputs covered by the bound assertions
        startErrors = totalErrors();
        wait (rstN);
        @(negedge clk);
        finishTest("resetState", startErrors);

        // Same line, offsets 3 and 4
        startErrors = totalErrors();
        request("coldRead", 1'b1, 1'b0, 16'h0123, '0);
        request("coldRead", 1'b1, 1'b0, 16'h0124, '0);
        finishTest("coldRead", startErrors);

        startErrors = totalErrors();
        request("writeRead", 1'b0, 1'b1, 16'h0200, 16'hbeef);
        request("writeRead", 1'b1, 1'b0, 16'h0200, '0);
        finishTest("writeRead", startErrors);

        // Index 0xb, second address differs only in the tag
        startErrors = totalErrors();
        request("evict", 1'b0, 1'b1, 16'h0358, 16'h5a5a);
        request("evict", 1'b1, 1'b0, 16'h03d8, '0);
        request("evict", 1'b1, 1'b0, 16'h0358, '0);
        finishTest("evict", startErrors);

        // Four tags over all 16 indices
        startErrors = totalErrors();
        for (int n = 0; n < RandomOps; n++) begin
            rngState = xorshift(rngState);
            r = rngState;
            addr = {7'b0, r[1:0], r[5:2], r[8:6]};
            case (r[11:10])
                2'd1: request("random", 1'b0, 1'b1, addr, r[31:16]);
                2'd2: request("random", 1'b1, 1'b1, addr, r[31:16]);
                default: request("random", 1'b1, 1'b0, addr, r[31:16]);
            endcase
        end
        finishTest("random", startErrors);

        $display("tests %0d, checks %0d, errors %0d", testsRun, checks, totalErrors());
        if (totalErrors() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Bound on the whole run, 30 cycles per request plus reset
    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", WatchdogCycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- sim/dataCacheL1_asserts.sv
// Control checks on the cache top level, bound into every dataCacheL1 instance
`timescale 1ns/10ps

module dataCacheL1Asserts (
    input logic clk,
    input logic rstN,
    input logic read,
    input logic write,
    input logic busy,
    input logic done,
    input logic hit
);

    // Failures seen so far, read by the testbench
    int failCount = 0;

    // Outputs quiet once reset has been seen on an edge
    assert property (@(posedge clk) (!rstN && $past(!rstN)) |-> (!busy && !done && !hit))
        else begin
            $error("busy, done or hit high during reset");
            failCount = failCount + 1;
        end

    // Single-cycle done pulse
    assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
        else begin
            $error("done high for more than one cycle");
            failCount = failCount + 1;
        end

    // Done closes a busy period
    assert property (@(posedge clk) disable iff (!rstN) $rose(done) |-> $past(busy))
        else begin
            $error("done without a preceding busy period");
            failCount = failCount + 1;
        end

    assert property (@(posedge clk) disable iff (!rstN) hit |-> done)
        else begin
            $error("hit high without done");
            failCount = failCount + 1;
        end

    // Busy rises on a sampled strobe
    assert property (@(posedge clk) disable iff (!rstN) (!busy && (read || write)) |=> busy)
        else begin
            $error("busy not raised after a sampled strobe");
            failCount = failCount + 1;
        end

    // and holds until done
    assert property (@(posedge clk) disable iff (!rstN) (busy && !done) |=> busy)
        else begin
            $error("busy dropped before done");
            failCount = failCount + 1;
        end

endmodule

bind dataCacheL1 dataCacheL1Asserts asserts (
    .clk(clk),
    .rstN(rstN),
    .read(read),
    .write(write),
    .busy(busy),
    .done(done),
    .hit(hit)
);

//--- source/cacheController.sv
// Cache controller decoding requests and sequencing lookup, write-back and refill
`timescale 1ns/10ps

module cacheController #(
    parameter int IndexBits = 11,
    localparam int TagBits = cachePkg::AddrWidth - IndexBits - cachePkg::OffsetBits
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    read,
    input  logic                    write,
    input  cachePkg::addrT          address,
    input  cachePkg::wordT          writeValue,
    output logic                    busy,
    output logic                    done,
    output logic                    hit,
    output cachePkg::wordT          readValue,
    output logic [IndexBits-1:0]    lineIndex,
    output cachePkg::wordOffsetT    wordSel,
    output logic                    wordWrite,
    output cachePkg::wordT          wordData,
    output logic                    tagWrite,
    output logic [TagBits-1:0]      newTag,
    output logic                    setValid,
    output logic                    setDirty,
    output logic                    clearDirty,
    input  logic [TagBits-1:0]      lineTag,
    input  logic                    lineValid,
    input  logic                    lineDirty,
    input  cachePkg::wordT          readWord,
    output cachePkg::addrT          memAddress,
    output logic                    memWrite,
    output cachePkg::wordT          memWriteData,
    input  cachePkg::wordT          memReadData
);

    // One extra step covers the memory read latency during refill
    localparam int StepBits = cachePkg::OffsetBits + 1;
    localparam logic [StepBits-1:0] LastWriteBack = StepBits'(cachePkg::LineWords - 1);
    localparam logic [StepBits-1:0] LastFill = StepBits'(cachePkg::LineWords);

    cachePkg::ctrlStateT    state;
    cachePkg::ctrlStateT    nextState;

    // Latched request
    logic                   reqWrite;
    logic [TagBits-1:0]     reqTag;
    logic [IndexBits-1:0]   reqIndex;
    cachePkg::wordOffsetT   reqOffset;
    cachePkg::wordT         reqData;

    logic [StepBits-1:0]    stepCount;
    cachePkg::wordOffsetT   stepOffset;
    cachePkg::wordOffsetT   fillOffset;
    logic                   hitFlag;
    logic                   tagMatch;
    logic                   request;

    assign request = read | write;
    assign tagMatch = lineValid && (lineTag == reqTag);
    assign stepOffset = stepCount[cachePkg::OffsetBits-1:0];
    // Word returned by memory lags the issued address by one step
    assign fillOffset = stepOffset - cachePkg::wordOffsetT'(1);

    assign busy = (state != cachePkg::Idle);
    assign done = (state == cachePkg::Complete);
    assign hit = done && hitFlag;

    always_comb begin
        nextState = state;
        unique case (state)
            cachePkg::Idle:
                if (request) nextState = cachePkg::Lookup;
            cachePkg::Lookup:
                if (tagMatch) nextState = cachePkg::Complete;
                else if (lineDirty) nextState = cachePkg::WriteBack;
                else nextState = cachePkg::Refill;
            cachePkg::WriteBack:
                if (stepCount == LastWriteBack) nextState = cachePkg::Refill;
            cachePkg::Refill:
                if (stepCount == LastFill) nextState = cachePkg::Complete;
            cachePkg::Complete:
                nextState = cachePkg::Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= cachePkg::Idle;
            stepCount <= '0;
            hitFlag <= 1'b0;
        end else begin
            state <= nextState;
            // Counter restarts at every state change
            if (nextState != state) stepCount <= '0;
            else stepCount <= stepCount + 1'b1;
            if (state == cachePkg::Lookup) hitFlag <= tagMatch;
        end
    end

    // Request capture on the sampling edge
    always_ff @(posedge clk) begin
        if (state == cachePkg::Idle && request) begin
            // Write wins over read
            reqWrite <= write;
            reqTag <= address[cachePkg::AddrWidth-1 -: TagBits];
            reqIndex <= address[cachePkg::OffsetBits +: IndexBits];
            reqOffset <= address[cachePkg::OffsetBits-1:0];
            reqData <= writeValue;
        end
    end

    // Read data ready on entry to Complete
    always_ff @(posedge clk) begin
        if (state == cachePkg::Lookup && tagMatch) begin
            readValue <= readWord;
        end else if (state == cachePkg::Refill && stepCount != '0 && fillOffset == reqOffset) begin
            // Take the requested word straight off the refill stream
            readValue <= memReadData;
        end
    end

    always_comb begin
        // Line store lookup runs ahead of the request latch while idle
        lineIndex = (state == cachePkg::Idle) ? address[cachePkg::OffsetBits +: IndexBits]
                                             : reqIndex;
        wordSel = reqOffset;
        wordWrite = 1'b0;
        wordData = reqData;
        tagWrite = 1'b0;
        newTag = reqTag;
        setValid = 1'b0;
        setDirty = 1'b0;
        clearDirty = 1'b0;
        memAddress = {reqTag, reqIndex, stepOffset};
        memWrite = 1'b0;
        memWriteData = readWord;
        unique case (state)
            cachePkg::Idle:
                wordSel = address[cachePkg::OffsetBits-1:0];
            cachePkg::Lookup:
                // Word 0 fetched early in case the victim must drain
                wordSel = '0;
            cachePkg::WriteBack: begin
                // Victim address from the resident tag
                wordSel = stepOffset + cachePkg::wordOffsetT'(1);
                memAddress = {lineTag, reqIndex, stepOffset};
                memWrite = 1'b1;
            end
            cachePkg::Refill: begin
                wordSel = fillOffset;
                wordData = memReadData;
                wordWrite = (stepCount != '0);
                if (stepCount == LastFill) begin
                    tagWrite = 1'b1;
                    setValid = 1'b1;
                    clearDirty = 1'b1;
                end
            end
            cachePkg::Complete:
                if (reqWrite) begin
                    wordWrite = 1'b1;
                    setDirty = 1'b1;
                end
        endcase
    end

endmodule

//--- source/cacheLineStore.sv
// Cache line store with data words, tags and per-line valid and dirty state
`timescale 1ns/10ps

module cacheLineStore #(
    parameter int IndexBits = 11,
    localparam int TagBits = cachePkg::AddrWidth - IndexBits - cachePkg::OffsetBits
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [IndexBits-1:0]    lineIndex,
    input  cachePkg::wordOffsetT    wordSel,
    input  logic                    wordWrite,
    input  cachePkg::wordT          wordData,
    input  logic                    tagWrite,
    input  logic [TagBits-1:0]      newTag,
    input  logic                    setValid,
    input  logic                    setDirty,
    input  logic                    clearDirty,
    output logic [TagBits-1:0]      lineTag,
    output logic                    lineValid,
    output logic                    lineDirty,
    output cachePkg::wordT          readWord
);

    localparam int Lines = 1 << IndexBits;
    localparam int WordCount = Lines * cachePkg::LineWords;

    typedef logic [TagBits-1:0] tagT;
    typedef logic [IndexBits+cachePkg::OffsetBits-1:0] wordAddrT;

    cachePkg::wordT     words [WordCount];
    tagT                tags [Lines];
    logic [Lines-1:0]   validBits;
    logic [Lines-1:0]   dirtyBits;
    wordAddrT           wordAddr;

    // Line index on top, word offset below
    assign wordAddr = {lineIndex, wordSel};

    // Data and tags, read before write
    always_ff @(posedge clk) begin
        if (wordWrite) words[wordAddr] <= wordData;
        if (tagWrite) tags[lineIndex] <= newTag;
        readWord <= words[wordAddr];
        lineTag <= tags[lineIndex];
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits <= '0;
            dirtyBits <= '0;
            lineValid <= 1'b0;
            lineDirty <= 1'b0;
        end else begin
            if (setValid) validBits[lineIndex] <= 1'b1;
            // Store hit marks dirty, finished refill cleans
            if (setDirty) dirtyBits[lineIndex] <= 1'b1;
            else if (clearDirty) dirtyBits[lineIndex] <= 1'b0;
            lineValid <= validBits[lineIndex];
            lineDirty <= dirtyBits[lineIndex];
        end
    end

endmodule

//--- source/cachePkg.sv
// Cache package holding the shared widths, word types and the controller state encoding
package cachePkg;

    // Main memory is word addressed
    localparam int AddrWidth = 16;

    // One data word
    localparam int WordWidth = 16;

    // Word position inside a line
    localparam int OffsetBits = 3;

    // Words per line
    localparam int LineWords = 1 << OffsetBits;

    // Full word address into main memory
    typedef logic [AddrWidth-1:0] addrT;

    // Data word as stored in cache and memory
    typedef logic [WordWidth-1:0] wordT;

    // Selects one word inside a line
    typedef logic [OffsetBits-1:0] wordOffsetT;

    // Controller sequence
    // Idle waits for a strobe, Lookup compares the tag,
    // WriteBack drains a dirty victim, Refill loads the new line,
    // Complete applies the access and signals done
    typedef enum logic [2:0] {
        Idle,
        Lookup,
        WriteBack,
        Refill,
        Complete
    } ctrlStateT;

endpackage

//--- source/dataCacheL1.sv
// Level-one data cache top, joining the controller, the line store and the backing memory
`timescale 1ns/10ps

module dataCacheL1 #(
    parameter int IndexBits = 11
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            read,
    input  logic            write,
    input  cachePkg::addrT  address,
    input  cachePkg::wordT  writeValue,
    output logic            busy,
    output logic            done,
    output logic            hit,
    output cachePkg::wordT  readValue
);

    localparam int TagBits = cachePkg::AddrWidth - IndexBits - cachePkg::OffsetBits;

    // Controller to line store
    logic [IndexBits-1:0]   lineIndex;
    cachePkg::wordOffsetT   wordSel;
    logic                   wordWrite;
    cachePkg::wordT         wordData;
    logic                   tagWrite;
    logic [TagBits-1:0]     newTag;
    logic                   setValid;
    logic                   setDirty;
    logic                   clearDirty;

    // Line store back to controller
    logic [TagBits-1:0]     lineTag;
    logic                   lineValid;
    logic                   lineDirty;
    cachePkg::wordT         readWord;

    // Memory side
    cachePkg::addrT         memAddress;
    logic                   memWrite;
    cachePkg::wordT         memWriteData;
    cachePkg::wordT         memReadData;

    cacheController #(
        .IndexBits(IndexBits)
    ) controller (
        .clk(clk),
        .rstN(rstN),
        .read(read),
        .write(write),
        .address(address),
        .writeValue(writeValue),
        .busy(busy),
        .done(done),
        .hit(hit),
        .readValue(readValue),
        .lineIndex(lineIndex),
        .wordSel(wordSel),
        .wordWrite(wordWrite),
        .wordData(wordData),
        .tagWrite(tagWrite),
        .newTag(newTag),
        .setValid(setValid),
        .setDirty(setDirty),
        .clearDirty(clearDirty),
        .lineTag(lineTag),
        .lineValid(lineValid),
        .lineDirty(lineDirty),
        .readWord(readWord),
        .memAddress(memAddress),
        .memWrite(memWrite),
        .memWriteData(memWriteData),
        .memReadData(memReadData)
    );

    cacheLineStore #(
        .IndexBits(IndexBits)
    ) lineStore (
        .clk(clk),
        .rstN(rstN),
        .lineIndex(lineIndex),
        .wordSel(wordSel),
        .wordWrite(wordWrite),
        .wordData(wordData),
        .tagWrite(tagWrite),
        .newTag(newTag),
        .setValid(setValid),
        .setDirty(setDirty),
        .clearDirty(clearDirty),
        .lineTag(lineTag),
        .lineValid(lineValid),
        .lineDirty(lineDirty),
        .readWord(readWord)
    );

    mainMemory memory (
        .clk(clk),
        .memAddress(memAddress),
        .memWrite(memWrite),
        .memWriteData(memWriteData),
        .memReadData(memReadData)
    );

endmodule

//--- source/mainMemory.sv
// Backing main memory with registered read and single-word write
`timescale 1ns/10ps

module mainMemory (
    input  logic            clk,
    input  cachePkg::addrT  memAddress,
    input  logic            memWrite,
    input  cachePkg::wordT  memWriteData,
    output cachePkg::wordT  memReadData
);

    // Whole 16-bit word address space
    localparam int Depth = 1 << cachePkg::AddrWidth;

    // Contents start cleared
    cachePkg::wordT mem [Depth] = '{default: '0};

    always_ff @(posedge clk) begin
        // One word per cycle
        if (memWrite) mem[memAddress] <= memWriteData;
        // Read returns the old word on a same-address write
        memReadData <= mem[memAddress];
    end

endmodule
